//--- Makefile
TOP = mipsCoreTb

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f mipsCore.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir

//--- bench/mipsCoreTb.sv
/*
 * Testbench for the core: random programs from fixed templates, loaded under reset.
 * Only forward branches are generated, and data lives from word 768 up, clear of code.
 */
module mipsCoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    localparam int N_TESTS = 8;
    localparam int MAX_LEN = 64;
    localparam int RST_CYCLES = 8;

    logic              clk;
    logic              rstN;
    logic              loadEn;
    logic [MEM_AW-1:0] loadAddr;
    logic [XLEN-1:0]   loadData;
    logic              retireValid;
    logic [4:0]        retireReg;
    logic [XLEN-1:0]   retireData;
    logic              halted;
    logic [XLEN-1:0]   progs [N_TESTS][MAX_LEN];
    int                lens [N_TESTS];
    logic [XLEN-1:0]   prog [MAX_LEN];    // image of the running test
    int                progLen;
    int                curTest;
    logic              testEnd;
    int                errCount;
    int                failedTests;
    int                seed;
    int                limit;             // watchdog budget in cycles

    mipsCore dut_i (
        .clk           (clk),
        .rstN_i        (rstN),
        .loadEn_i      (loadEn),
        .loadAddr_i    (loadAddr),
        .loadData_i    (loadData),
        .retireValid_o (retireValid),
        .retireReg_o   (retireReg),
        .retireData_o  (retireData),
        .halted_o      (halted)
    );

    retireChecker #(.MAX_LEN(MAX_LEN)) retireChk (
        .clk           (clk),
        .rstN_i        (rstN),
        .retireValid_i (retireValid),
        .retireReg_i   (retireReg),
        .retireData_i  (retireData),
        .halted_i      (halted),
        .prog_i        (prog),
        .progLen_i     (progLen),
        .testId_i      (curTest),
        .testEnd_i     (testEnd),
        .errCount_o    (errCount),
        .failedTests_o (failedTests)
    );

    always #5 clk = ~clk;

    function automatic int pick(int n);
        int v;
        v = $random(seed) & 32'h7fff_ffff;
        return v % n;
    endfunction

    function automatic logic [4:0] pickReg(int lo, int hi);
        return 5'(lo + pick(hi - lo + 1));
    endfunction

    function automatic logic [15:0] rand16();
        return 16'($random(seed));
    endfunction

    function automatic logic [31:0] encR(logic [5:0] fn, logic [4:0] rd,
                                         logic [4:0] rs, logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rt,
                                         logic [4:0] rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] aluInstr(int kind, logic [4:0] rd,
                                             logic [4:0] rs, logic [4:0] rt);
        case (kind)
            0:       return encR(FN_ADDU, rd, rs, rt);
            1:       return encR(FN_SUBU, rd, rs, rt);
            2:       return encR(FN_AND, rd, rs, rt);
            3:       return encR(FN_OR, rd, rs, rt);
            4:       return encR(FN_SLT, rd, rs, rt);
            5:       return encI(OP_ADDIU, rd, rs, rand16());
            default: return encI(OP_LUI, rd, 5'd0, rand16());
        endcase
    endfunction

    task automatic emit(int t, logic [31:0] w);
        progs[t][lens[t]] = w;
        lens[t]++;
    endtask

    task automatic buildAlu(int t);
        logic [4:0] rd;
        for (int k = 1; k <= 6; k++) begin
            emit(t, encI(OP_LUI, 5'(k), 5'd0, rand16()));
            emit(t, encI(OP_ADDIU, 5'(k), 5'(k), rand16()));
        end
        for (int j = 0; j < 14; j++) begin
            rd = (pick(4) == 0) ? 5'd0 : pickReg(7, 31);   // r0 writes stay silent
            emit(t, aluInstr(pick(7), rd, pickReg(1, 6), pickReg(1, 6)));
        end
    endtask

    task automatic buildChain(int t);
        logic [4:0] prev;
        logic [4:0] rd;
        emit(t, encI(OP_ADDIU, 5'd1, 5'd0, rand16()));
        prev = 5'd1;
        for (int j = 0; j < 14; j++) begin
            rd = pickReg(1, 31);
            emit(t, aluInstr(pick(6), rd, prev, (pick(2) == 1) ? prev : pickReg(1, 31)));
            prev = rd;
        end
    endtask

    task automatic buildMem(int t);
        emit(t, encI(OP_ADDIU, 5'd20, 5'd0, 16'h0c00));   // base at word 768
        for (int k = 0; k < 4; k++) begin
            emit(t, encI(OP_LUI, 5'(1 + k), 5'd0, rand16()));
            emit(t, encI(OP_ADDIU, 5'(1 + k), 5'(1 + k), rand16()));
        end
        for (int k = 0; k < 4; k++) emit(t, encI(OP_SW, 5'(1 + k), 5'd20, 16'(4 * k)));
        for (int k = 0; k < 4; k++) emit(t, encI(OP_LW, 5'(5 + k), 5'd20, 16'(12 - 4 * k)));
        emit(t, encI(OP_SW, 5'd2, 5'd20, 16'd32));
        emit(t, encI(OP_LW, 5'd9, 5'd20, 16'd32));
        emit(t, encR(FN_ADDU, 5'd10, 5'd9, 5'd3));        // load-use pair
        emit(t, encI(OP_LW, 5'd11, 5'd20, 16'(4 * pick(4))));
        emit(t, encI(OP_SW, 5'd11, 5'd20, 16'd36));       // stores the word just loaded
        emit(t, encI(OP_LW, 5'd12, 5'd20, 16'd36));
        emit(t, encR(FN_OR, 5'd13, 5'd12, 5'd12));
    endtask

    task automatic buildBranch(int t);
        logic [5:0] op;
        int         skip;
        for (int k = 1; k <= 3; k++) emit(t, encI(OP_ADDIU, 5'(k), 5'd0, 16'(pick(4))));
        for (int k = 0; k < 6; k++) begin
            skip = 1 + pick(2);
            op = (pick(2) == 1) ? OP_BNE : OP_BEQ;
            emit(t, encI(OP_ADDIU, 5'(1 + pick(3)), 5'(1 + pick(3)), 16'(pick(3) - 1)));
            emit(t, encI(op, pickReg(1, 3), pickReg(1, 3), 16'(skip)));
            for (int j = 0; j < skip; j++) begin
                emit(t, encI(OP_ADDIU, 5'(10 + j), 5'(10 + j), 16'd1));  // skipped if taken
            end
            emit(t, encI(OP_ADDIU, 5'(20 + k), 5'd1, 16'(k)));   // on both paths
        end
    endtask

    task automatic runTest(int t);
        @(negedge clk);
        rstN = 1'b0;
        curTest = t;
        progLen = lens[t];
        for (int i = 0; i < MAX_LEN; i++) prog[i] = (i < lens[t]) ? progs[t][i] : '0;
        for (int i = 0; i < lens[t]; i++) begin
            loadEn = 1'b1;
            loadAddr = MEM_AW'(i);
            loadData = progs[t][i];
            @(negedge clk);
        end
        loadEn = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rstN = 1'b1;
        while (!halted) @(negedge clk);
        repeat (10) @(negedge clk);   // late retirements would show here
        testEnd = 1'b1;
        @(negedge clk);
        testEnd = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        testEnd = 1'b0;
        curTest = 0;
        progLen = 0;
        seed = 32'hc34fbaf6;
        limit = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            lens[t] = 0;
            case (t % 4)
                0:       buildAlu(t);
                1:       buildChain(t);
                2:       buildMem(t);
                default: buildBranch(t);
            endcase
            emit(t, encR(FN_SYSCALL, 5'd0, 5'd0, 5'd0));   // HALT
        end
        // program length bounds the retirements of each test
        for (int t = 0; t < N_TESTS; t++) limit += 40 * lens[t] + lens[t] + RST_CYCLES + 16;
        for (int t = 0; t < N_TESTS; t++) runTest(t);
        $display("%0d tests run, %0d failed, %0d errors", N_TESTS, failedTests, errCount);
        if (errCount == 0 && failedTests == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, test %0d never reached halt", limit, curTest);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- bench/retireChecker.sv
/*
 * Runs the loaded program through an instruction-level model when reset releases,
 * then compares every retire report with it in program order.
 * Memory outside the program reads as zero, so loads must read stored words only.
 */
module retireChecker #(
    parameter int MAX_LEN = 64
) (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    retireValid_i,
    input  logic [4:0]              retireReg_i,
    input  logic [cpuPkg::XLEN-1:0] retireData_i,
    input  logic                    halted_i,
    input  logic [cpuPkg::XLEN-1:0] prog_i [MAX_LEN],
    input  int                      progLen_i,
    input  int                      testId_i,
    input  logic                    testEnd_i,
    output int                      errCount_o,
    output int                      failedTests_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    logic [4:0]      expReg [MAX_LEN];
    logic [XLEN-1:0] expData [MAX_LEN];
    int              expCount = 0;
    int              idx = 0;          // next expected retirement
    int              testErrs = 0;
    int              errCount = 0;
    int              failedTests = 0;
    logic            inReset = 1'b0;   // reset seen at the previous edge
    logic            haltSeen = 1'b0;

    assign errCount_o    = errCount;
    assign failedTests_o = failedTests;

    // plain ISA semantics, no delay slot, stops at SYSCALL
    function automatic int runModel();
        logic [XLEN-1:0] r [32];
        logic [XLEN-1:0] mem [MEM_WORDS];
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] nextPc;
        logic [XLEN-1:0] ins;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] val;
        logic [4:0]      dest;
        logic            wr;
        logic            stop;
        int              n;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = '0;
        for (int i = 0; i < progLen_i && i < MAX_LEN; i++) mem[i] = prog_i[i];
        n = 0;
        pc = RESET_PC;
        stop = 1'b0;
        for (int step = 0; step < 8 * MAX_LEN && !stop; step++) begin
            ins = mem[pc[MEM_AW+1:2]];
            a = r[ins[25:21]];
            b = r[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            nextPc = pc + 32'd4;
            wr = 1'b0;
            dest = ins[20:16];
            val = '0;
            case (ins[31:26])
                OP_RTYPE: begin
                    dest = ins[15:11];
                    wr = 1'b1;
                    case (ins[5:0])
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND:  val = a & b;
                        FN_OR:   val = a | b;
                        FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SYSCALL: begin
                            wr = 1'b0;
                            stop = 1'b1;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    wr = 1'b1;
                    val = addr;
                end
                OP_LUI: begin
                    wr = 1'b1;
                    val = {ins[15:0], 16'h0000};
                end
                OP_LW: begin
                    wr = 1'b1;
                    val = mem[addr[MEM_AW+1:2]];
                end
                OP_SW:  mem[addr[MEM_AW+1:2]] = b;
                OP_BEQ: if (a == b) nextPc = pc + 32'd4 + (imm << 2);
                OP_BNE: if (a != b) nextPc = pc + 32'd4 + (imm << 2);
                default: ;
            endcase
            if (wr && dest != 5'd0 && n < MAX_LEN) begin
                r[dest] = val;
                expReg[n] = dest;
                expData[n] = val;
                n++;
            end
            pc = nextPc;
        end
        return n;
    endfunction

    task automatic flagError();
        testErrs++;
        errCount++;
    endtask

    task automatic checkRetire();
        if (haltSeen) begin
            $display("test %0d: r%0d retired after halted_o rose", testId_i, retireReg_i);
            flagError();
        end else if (idx >= expCount) begin
            $display("test %0d: extra retirement of r%0d beyond the %0d expected",
                     testId_i, retireReg_i, expCount);
            flagError();
        end else begin
            if (retireReg_i !== expReg[idx] || retireData_i !== expData[idx]) begin
                $display("ERR %0t: test %0d retire #%0d expected r%0d=%08h, got r%0d=%08h",
                         $time, testId_i, idx, expReg[idx], expData[idx],
                         retireReg_i, retireData_i);
                flagError();
            end
            idx++;
        end
    endtask

    task automatic endTest();
        if (!haltSeen) begin
            $display("test %0d: halted_o never rose", testId_i);
            flagError();
        end
        if (testErrs == 0) begin
            $display("test %0d passed, %0d retirements checked", testId_i, idx);
        end else begin
            $display("test %0d failed with %0d errors", testId_i, testErrs);
            failedTests++;
        end
        testErrs = 0;
    endtask

    always @(posedge clk) begin
        if (!rstN_i) begin
            // first edge of reset still shows the previous test's state
            if (inReset && retireValid_i) begin
                $display("test %0d: retirement reported while reset is asserted", testId_i);
                flagError();
            end
            if (inReset && halted_i) begin
                $display("test %0d: halted_o high while reset is asserted", testId_i);
                flagError();
            end
            inReset = 1'b1;
        end else begin
            if (inReset) begin
                expCount = runModel();
                idx = 0;
                haltSeen = 1'b0;
            end
            inReset = 1'b0;
            if (retireValid_i) checkRetire();
            if (halted_i && !haltSeen) begin
                haltSeen = 1'b1;
                if (idx != expCount) begin
                    $display("test %0d: halted after %0d of %0d expected retirements",
                             testId_i, idx, expCount);
                    flagError();
                end
            end
            if (testEnd_i) endTest();
        end
    end

endmodule

//--- logic/cpuPkg.sv
/*
 * Shared constants and types of the core.
 * Only the listed MIPS integer subset is decoded; anything else is a no-op.
 * HALT is the SYSCALL encoding and stops fetch for good.
 */
package cpuPkg;

    localparam int XLEN = 32;
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW = $clog2(MEM_WORDS);  // word address width
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // function field of R-type
    localparam logic [5:0] FN_SYSCALL = 6'h0c;  // used as HALT
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } aluOpT;

    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } wbT;

    typedef struct packed {
        logic            valid;
        logic            isLoad;
        logic            isStore;
        logic [4:0]      rd;         // 0 for stores and no-ops
        logic [XLEN-1:0] result;     // ALU result or byte address
        logic [XLEN-1:0] storeData;
    } exMemT;

endpackage

//--- logic/execStage.sv
/*
 * Decode, register file, ALU and branch resolution, one instruction per cycle.
 * ALU results forward from the memory stage; loads forward only at write-back,
 * so a dependent instruction waits. Branches have no delay slot.
 * HALT stays at the queue head and sets halt_o once the memory stage is empty.
 */
module execStage (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    instrValid_i,
    output logic                    instrReady_o,
    input  logic [cpuPkg::XLEN-1:0] instr_i,
    input  logic [cpuPkg::XLEN-1:0] instrPc_i,
    input  cpuPkg::wbT              wb_i,
    output cpuPkg::exMemT           out_o,
    output logic                    outValid_o,
    input  logic                    outReady_i,
    output logic                    redirect_o,
    output logic [cpuPkg::XLEN-1:0] redirectPc_o,
    output logic                    halt_o
);
    import cpuPkg::*;

    logic [XLEN-1:0] regs [32];
    logic [5:0]      opcode;
    logic [5:0]      funct;
    logic [4:0]      rs;
    logic [4:0]      rt;
    logic [4:0]      dst;
    logic [XLEN-1:0] immSext;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluResult;
    aluOpT           aluOp;
    logic            useImm;
    logic            isLoad;
    logic            isStore;
    logic            isBranch;
    logic            isHalt;
    logic            hazard;
    logic            halted;
    // copy of the instruction now held by the memory stage
    logic            fwdValid;
    logic            fwdIsLoad;
    logic [4:0]      fwdRd;
    logic [XLEN-1:0] fwdData;

    assign opcode  = instr_i[31:26];
    assign rs      = instr_i[25:21];
    assign rt      = instr_i[20:16];
    assign funct   = instr_i[5:0];
    assign immSext = {{16{instr_i[15]}}, instr_i[15:0]};

    assign isLoad   = (opcode == OP_LW);
    assign isStore  = (opcode == OP_SW);
    assign isBranch = (opcode == OP_BEQ) || (opcode == OP_BNE);
    assign isHalt   = (opcode == OP_RTYPE) && (funct == FN_SYSCALL);

    always_comb begin
        aluOp  = ALU_ADD;
        useImm = 1'b0;
        dst    = 5'd0;
        case (opcode)
            OP_RTYPE: begin
                dst = instr_i[15:11];
                case (funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_SLT:  aluOp = ALU_SLT;
                    default: dst = 5'd0;    // HALT and unknown funct write nothing
                endcase
            end
            OP_ADDIU, OP_LW: begin
                useImm = 1'b1;
                dst    = rt;
            end
            OP_LUI: begin
                aluOp  = ALU_LUI;
                useImm = 1'b1;
                dst    = rt;
            end
            OP_SW:   useImm = 1'b1;     // address only
            default: ;
        endcase
    end

    // memory-stage result first, then the write-back in this cycle
    assign opA = (rs == 5'd0) ? '0 :
                 (fwdValid && fwdRd == rs) ? fwdData :
                 (wb_i.we && wb_i.rd == rs) ? wb_i.data : regs[rs];
    assign opB = (rt == 5'd0) ? '0 :
                 (fwdValid && fwdRd == rt) ? fwdData :
                 (wb_i.we && wb_i.rd == rt) ? wb_i.data : regs[rt];

    assign hazard = fwdValid && fwdIsLoad && (fwdRd != 5'd0) && (fwdRd == rs || fwdRd == rt);

    assign srcB = useImm ? immSext : opB;

    always_comb begin
        case (aluOp)
            ALU_SUB: aluResult = opA - srcB;
            ALU_AND: aluResult = opA & srcB;
            ALU_OR:  aluResult = opA | srcB;
            ALU_SLT: aluResult = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(srcB)};
            ALU_LUI: aluResult = {srcB[15:0], 16'h0000};
            default: aluResult = opA + srcB;
        endcase
    end

    assign redirect_o   = instrValid_i && !hazard && isBranch &&
                          ((opA == opB) ^ (opcode == OP_BNE));
    assign redirectPc_o = instrPc_i + 32'd4 + {immSext[XLEN-3:0], 2'b00};

    // branches finish here, HALT never leaves
    assign outValid_o   = instrValid_i && !hazard && !isBranch && !isHalt;
    assign instrReady_o = !hazard && !isHalt && (isBranch || outReady_i);

    assign out_o.valid     = outValid_o;
    assign out_o.isLoad    = isLoad;
    assign out_o.isStore   = isStore;
    assign out_o.rd        = dst;
    assign out_o.result    = aluResult;
    assign out_o.storeData = opB;

    assign halt_o = halted;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            fwdValid <= 1'b0;
            halted   <= 1'b0;
            for (int i = 0; i < 32; i++) regs[i] <= '0;   // registers start at zero
        end else begin
            if (outReady_i) fwdValid <= outValid_o;     // memory stage keeps it otherwise
            if (instrValid_i && isHalt && !fwdValid) halted <= 1'b1;
            if (wb_i.we) regs[wb_i.rd] <= wb_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (outValid_o && outReady_i) begin
            fwdIsLoad <= isLoad;
            fwdRd     <= dst;
            fwdData   <= aluResult;
        end
    end

endmodule

//--- logic/fetchUnit.sv
/*
 * PC and two-entry instruction queue.
 * A redirect empties the queue and drops the response arriving in that cycle.
 * No new request goes out in reset, while redirecting or once halt_i is high.
 */
module fetchUnit (
    input  logic                    clk,
    input  logic                    rstN_i,
    memBusIf.requester              bus,
    output logic                    instrValid_o,
    input  logic                    instrReady_i,
    output logic [cpuPkg::XLEN-1:0] instr_o,
    output logic [cpuPkg::XLEN-1:0] instrPc_o,
    input  logic                    redirect_i,
    input  logic [cpuPkg::XLEN-1:0] redirectPc_i,
    input  logic                    halt_i
);
    import cpuPkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pendPc;        // pc of the read in flight
    logic [XLEN-1:0] qInstr [2];
    logic [XLEN-1:0] qPc [2];
    logic            qHead;
    logic [1:0]      qCount;
    logic [1:0]      occ;
    logic            tail;
    logic            push;
    logic            pop;
    logic            xfer;

    assign pop  = instrValid_o & instrReady_i;
    assign push = bus.rspValid & ~redirect_i;   // wrong-path word is dropped
    assign xfer = bus.reqValid & bus.reqReady;
    assign tail = qHead ^ qCount[0];

    // rspValid marks the only read that can be outstanding
    assign occ = qCount + 2'(bus.rspValid);

    assign bus.reqValid = rstN_i & ~halt_i & ~redirect_i & ((occ != 2'd2) | pop);
    assign bus.addr     = pc[MEM_AW+1:2];
    assign bus.we       = 1'b0;
    assign bus.wdata    = '0;

    assign instrValid_o = (qCount != 2'd0);
    assign instr_o      = qInstr[qHead];
    assign instrPc_o    = qPc[qHead];

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pc     <= RESET_PC;
            qHead  <= 1'b0;
            qCount <= 2'd0;
        end else if (redirect_i) begin
            pc     <= redirectPc_i;
            qCount <= 2'd0;
        end else begin
            if (xfer) pc <= pc + 32'd4;
            if (pop) qHead <= ~qHead;
            qCount <= qCount + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) pendPc <= pc;
        if (push) begin
            qInstr[tail] <= bus.rdata;
            qPc[tail]    <= pendPc;
        end
    end

endmodule

//--- logic/memArbiter.sv
/*
 * Fixed-priority arbiter for the single memory port, data before fetch.
 * One grant per cycle; a read answers on its owner's bus one cycle later.
 */
module memArbiter (
    input  logic                      clk,
    input  logic                      rstN_i,
    memBusIf.arbiter                  fetchBus,
    memBusIf.arbiter                  dataBus,
    output logic                      memEn_o,
    output logic                      memWe_o,
    output logic [cpuPkg::MEM_AW-1:0] memAddr_o,
    output logic [cpuPkg::XLEN-1:0]   memWdata_o,
    input  logic [cpuPkg::XLEN-1:0]   memRdata_i
);

    logic dataGnt;
    logic fetchGnt;
    logic dataRdPend;   // read in flight belongs to data
    logic fetchRdPend;

    assign dataGnt  = dataBus.reqValid;
    assign fetchGnt = fetchBus.reqValid & ~dataBus.reqValid;

    assign dataBus.reqReady  = dataGnt;
    assign fetchBus.reqReady = fetchGnt;

    assign memEn_o    = dataGnt | fetchGnt;
    assign memWe_o    = dataGnt ? dataBus.we : (fetchGnt & fetchBus.we);
    assign memAddr_o  = dataGnt ? dataBus.addr : fetchBus.addr;
    assign memWdata_o = dataGnt ? dataBus.wdata : fetchBus.wdata;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            dataRdPend  <= 1'b0;
            fetchRdPend <= 1'b0;
        end else begin
            dataRdPend  <= dataGnt & ~dataBus.we;
            fetchRdPend <= fetchGnt & ~fetchBus.we;
        end
    end

    // the memory has one registered read port, so both see the same word
    assign dataBus.rspValid  = dataRdPend;
    assign dataBus.rdata     = memRdata_i;
    assign fetchBus.rspValid = fetchRdPend;
    assign fetchBus.rdata    = memRdata_i;

endmodule

//--- logic/memBusIf.sv
/*
 * One requester's link to the memory arbiter.
 * Request holds until reqValid and reqReady meet; read data follows one cycle later.
 * At most one read in flight per requester, writes get no response.
 */
interface memBusIf;
    import cpuPkg::*;

    logic              reqValid;
    logic              reqReady;
    logic [MEM_AW-1:0] addr;      // word address
    logic              we;
    logic [XLEN-1:0]   wdata;
    logic              rspValid;
    logic [XLEN-1:0]   rdata;

    modport requester (
        output reqValid, addr, we, wdata,
        input  reqReady, rspValid, rdata
    );

    modport arbiter (
        input  reqValid, addr, we, wdata,
        output reqReady, rspValid, rdata
    );

endinterface

//--- logic/memStage.sv
/*
 * Holds one instruction and does its LW or SW over the shared bus.
 * Write-back and retire report are registered, one cycle after completion.
 * Stores and writes to register 0 retire without a report.
 */
module memStage (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  cpuPkg::exMemT           in_i,
    input  logic                    inValid_i,
    output logic                    inReady_o,
    memBusIf.requester              bus,
    output cpuPkg::wbT              wb_o,
    output logic                    retireValid_o,
    output logic [4:0]              retireReg_o,
    output logic [cpuPkg::XLEN-1:0] retireData_o
);
    import cpuPkg::*;

    exMemT cur;
    logic  reqSent;     // load accepted, data due next cycle
    logic  done;

    assign bus.reqValid = cur.valid & (cur.isLoad | cur.isStore) & ~reqSent;
    assign bus.addr     = cur.result[MEM_AW+1:2];
    assign bus.we       = cur.isStore;
    assign bus.wdata    = cur.storeData;

    always_comb begin
        if (cur.isLoad) done = cur.valid & bus.rspValid;
        else if (cur.isStore) done = bus.reqValid & bus.reqReady;
        else done = cur.valid;
    end

    assign inReady_o = ~cur.valid | done;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            cur.valid <= 1'b0;
            reqSent   <= 1'b0;
            wb_o.we   <= 1'b0;
        end else begin
            if (inReady_o) begin
                cur       <= in_i;
                cur.valid <= inValid_i;
            end
            reqSent <= (bus.reqValid & bus.reqReady & cur.isLoad) | (reqSent & ~bus.rspValid);
            wb_o.we <= done & ~cur.isStore & (cur.rd != 5'd0);
            if (done) begin
                wb_o.rd   <= cur.rd;
                wb_o.data <= cur.isLoad ? bus.rdata : cur.result;
            end
        end
    end

    assign retireValid_o = wb_o.we;
    assign retireReg_o   = wb_o.rd;
    assign retireData_o  = wb_o.data;

endmodule

//--- logic/mipsCore.sv
/*
 * Three-stage MIPS subset core on one unified memory.
 * loadEn_i writes memory directly and is meant only for use during reset.
 * Each register write shows on the retire ports for one cycle.
 */
module mipsCore (
    input  logic                      clk,
    input  logic                      rstN_i,
    input  logic                      loadEn_i,
    input  logic [cpuPkg::MEM_AW-1:0] loadAddr_i,
    input  logic [cpuPkg::XLEN-1:0]   loadData_i,
    output logic                      retireValid_o,
    output logic [4:0]                retireReg_o,
    output logic [cpuPkg::XLEN-1:0]   retireData_o,
    output logic                      halted_o
);
    import cpuPkg::*;

    logic              instrValid;
    logic              instrReady;
    logic [XLEN-1:0]   instr;
    logic [XLEN-1:0]   instrPc;
    logic              redirect;
    logic [XLEN-1:0]   redirectPc;
    wbT                wb;
    exMemT             exMem;
    logic              exMemValid;
    logic              exMemReady;
    logic              memEn;
    logic              memWe;
    logic [MEM_AW-1:0] memAddr;
    logic [XLEN-1:0]   memWdata;
    logic [XLEN-1:0]   memRdata;

    memBusIf fetchBus ();
    memBusIf dataBus ();

    fetchUnit uFetch (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .bus          (fetchBus),
        .instrValid_o (instrValid),
        .instrReady_i (instrReady),
        .instr_o      (instr),
        .instrPc_o    (instrPc),
        .redirect_i   (redirect),
        .redirectPc_i (redirectPc),
        .halt_i       (halted_o)
    );

    execStage uExec (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .instrValid_i (instrValid),
        .instrReady_o (instrReady),
        .instr_i      (instr),
        .instrPc_i    (instrPc),
        .wb_i         (wb),
        .out_o        (exMem),
        .outValid_o   (exMemValid),
        .outReady_i   (exMemReady),
        .redirect_o   (redirect),
        .redirectPc_o (redirectPc),
        .halt_o       (halted_o)
    );

    memStage uMem (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .in_i          (exMem),
        .inValid_i     (exMemValid),
        .inReady_o     (exMemReady),
        .bus           (dataBus),
        .wb_o          (wb),
        .retireValid_o (retireValid_o),
        .retireReg_o   (retireReg_o),
        .retireData_o  (retireData_o)
    );

    memArbiter uArb (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .fetchBus   (fetchBus),
        .dataBus    (dataBus),
        .memEn_o    (memEn),
        .memWe_o    (memWe),
        .memAddr_o  (memAddr),
        .memWdata_o (memWdata),
        .memRdata_i (memRdata)
    );

    unifiedMem uRam (
        .clk        (clk),
        .en_i       (memEn),
        .we_i       (memWe),
        .addr_i     (memAddr),
        .wdata_i    (memWdata),
        .rdata_o    (memRdata),
        .loadEn_i   (loadEn_i),
        .loadAddr_i (loadAddr_i),
        .loadData_i (loadData_i)
    );

endmodule

//--- logic/unifiedMem.sv
/*
 * Word-addressed RAM shared by instructions and data.
 * Read data is registered and holds until the next read.
 * The load port is meant for use during reset and wins over the bus write.
 */
module unifiedMem (
    input  logic                      clk,
    input  logic                      en_i,
    input  logic                      we_i,
    input  logic [cpuPkg::MEM_AW-1:0] addr_i,
    input  logic [cpuPkg::XLEN-1:0]   wdata_i,
    output logic [cpuPkg::XLEN-1:0]   rdata_o,
    input  logic                      loadEn_i,
    input  logic [cpuPkg::MEM_AW-1:0] loadAddr_i,
    input  logic [cpuPkg::XLEN-1:0]   loadData_i
);
    import cpuPkg::*;

    logic [XLEN-1:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (loadEn_i) begin
            mem[loadAddr_i] <= loadData_i;  // program load
        end else if (en_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end
        if (en_i && !we_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

//--- mipsCore.f
logic/cpuPkg.sv
logic/memBusIf.sv
logic/memArbiter.sv
logic/unifiedMem.sv
logic/fetchUnit.sv
logic/execStage.sv
logic/memStage.sv
logic/mipsCore.sv
bench/retireChecker.sv
bench/mipsCoreTb.sv
